/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// operand and register file sizes
`define NUM_SRC     2
`define NUM_REGS    32
`define REG_LINK    5'd31       // jal writes here

// primary opcodes
`define OP_SPECIAL  6'h00
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// function codes under OP_SPECIAL
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_JR       6'h08
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// exception codes
`define EX_NO       5'h1f       // no exception pending
`define EX_ADEL     5'h04
`define EX_RI       5'h0a

`endif

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // general register index
    typedef logic [4:0] reg_idx_t;

    // one-hot alu operation
    // bit 0 add, 1 sub, 2 slt, 3 sltu, 4 and, 5 nor,
    // 6 or, 7 xor, 8 sll, 9 srl, 10 sra, 11 lui
    typedef logic [11:0] alu_op_t;

    // control transfer kinds seen in decode
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_J    = 3'd3,
        BR_JAL  = 3'd4,
        BR_JR   = 3'd5
    } br_kind_t;

    // exception code as carried down the pipe
    typedef logic [4:0] excode_t;

endpackage

`default_nettype wire

/* src/decode_latch.sv */
`default_nettype none

`include "cpu_defs.svh"

module decode_latch import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fs_to_ds_valid,
    input  word_t fs_pc,
    input  word_t fs_inst,
    input  logic  fs_adel,
    input  logic  es_allowin,
    input  logic  ws_flush,
    input  logic  load_hit [`NUM_SRC],
    output logic  ds_allowin,
    output logic  ds_valid,
    output word_t ds_pc,
    output word_t ds_inst,
    output logic  ds_adel,
    output logic  ds_ready_go,
    output logic  ds_to_es_valid
);

    logic load_stall;   // some read operand waits on a load in exe

    always_comb begin
        load_stall = 1'b0;
        for (int i = 0; i < `NUM_SRC; i++) begin
            load_stall = load_stall | load_hit[i];
        end
    end

    assign ds_ready_go    = ~load_stall;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go & ~ws_flush;   // flush kills the handoff

    // stage occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;   // empties when fetch has nothing
        end
    end

    // fetch payload, held while stalled or back-pressured
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
            ds_adel <= fs_adel;
        end
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`default_nettype none

`include "cpu_defs.svh"

module instr_decoder import cpu_pkg::*; (
    input  word_t        ds_inst,
    input  logic         ds_valid,
    input  logic         ds_adel,
    output reg_idx_t     src_idx [`NUM_SRC],
    output logic         src_used [`NUM_SRC],
    output alu_op_t      alu_op,
    output logic         src1_is_sa,
    output logic         src1_is_pc,
    output logic         src2_is_imm,
    output logic         src2_is_8,
    output logic         zero_ext,
    output logic         load_op,
    output logic         store_op,
    output logic         gr_we,
    output reg_idx_t     dest,
    output logic [15:0]  imm,
    output logic [25:0]  jidx,
    output br_kind_t     br_kind,
    output logic         ds_ex,
    output excode_t      ds_excode
);

    logic [5:0] op;
    logic [5:0] func;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] sa;
    logic       special;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic imm_form;     // alu ops taking the 16-bit immediate
    logic no_dest;
    logic known;

    assign op   = ds_inst[31:26];
    assign rs   = ds_inst[25:21];
    assign rt   = ds_inst[20:16];
    assign rd   = ds_inst[15:11];
    assign sa   = ds_inst[10:6];
    assign func = ds_inst[5:0];
    assign imm  = ds_inst[15:0];
    assign jidx = ds_inst[25:0];

    assign special = (op == `OP_SPECIAL);

    // r-type, unused fields must be zero
    assign inst_addu = special && func == `FN_ADDU && sa == 5'd0;
    assign inst_subu = special && func == `FN_SUBU && sa == 5'd0;
    assign inst_slt  = special && func == `FN_SLT  && sa == 5'd0;
    assign inst_sltu = special && func == `FN_SLTU && sa == 5'd0;
    assign inst_and  = special && func == `FN_AND  && sa == 5'd0;
    assign inst_or   = special && func == `FN_OR   && sa == 5'd0;
    assign inst_xor  = special && func == `FN_XOR  && sa == 5'd0;
    assign inst_nor  = special && func == `FN_NOR  && sa == 5'd0;
    assign inst_sll  = special && func == `FN_SLL  && rs == 5'd0;
    assign inst_srl  = special && func == `FN_SRL  && rs == 5'd0;
    assign inst_sra  = special && func == `FN_SRA  && rs == 5'd0;
    assign inst_jr   = special && func == `FN_JR   && rt == 5'd0 && rd == 5'd0 && sa == 5'd0;

    assign inst_addiu = (op == `OP_ADDIU);
    assign inst_slti  = (op == `OP_SLTI);
    assign inst_sltiu = (op == `OP_SLTIU);
    assign inst_andi  = (op == `OP_ANDI);
    assign inst_ori   = (op == `OP_ORI);
    assign inst_xori  = (op == `OP_XORI);
    assign inst_lui   = (op == `OP_LUI) && rs == 5'd0;
    assign inst_lw    = (op == `OP_LW);
    assign inst_sw    = (op == `OP_SW);
    assign inst_beq   = (op == `OP_BEQ);
    assign inst_bne   = (op == `OP_BNE);
    assign inst_j     = (op == `OP_J);
    assign inst_jal   = (op == `OP_JAL);

    assign imm_form = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                    | inst_xori | inst_lui;
    assign no_dest  = inst_sw | inst_beq | inst_bne | inst_j | inst_jr;

    assign known = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                 | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_jr
                 | imm_form | inst_lw | inst_sw | inst_beq | inst_bne | inst_j | inst_jal;

    // source 0 is rs, source 1 is rt
    assign src_idx[0]  = rs;
    assign src_idx[1]  = rt;
    assign src_used[0] = ~(inst_j | inst_jal);
    assign src_used[1] = ~(imm_form | inst_lw | inst_j | inst_jal);

    assign alu_op = {inst_lui, inst_sra, inst_srl, inst_sll,
                     inst_xor | inst_xori, inst_or | inst_ori, inst_nor, inst_and | inst_andi,
                     inst_sltu | inst_sltiu, inst_slt | inst_slti, inst_subu,
                     inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal};  // jal adds pc+8

    assign src1_is_sa  = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc  = inst_jal;
    assign src2_is_imm = imm_form | inst_lw | inst_sw;
    assign src2_is_8   = inst_jal;
    assign zero_ext    = inst_andi | inst_ori | inst_xori;
    assign load_op     = inst_lw;
    assign store_op    = inst_sw;
    assign gr_we       = ~no_dest;

    assign dest = inst_jal              ? `REG_LINK :
                  (imm_form | inst_lw)  ? rt        :
                  no_dest               ? 5'd0      :
                                          rd;

    always_comb begin
        if (inst_beq)      br_kind = BR_BEQ;
        else if (inst_bne) br_kind = BR_BNE;
        else if (inst_j)   br_kind = BR_J;
        else if (inst_jal) br_kind = BR_JAL;
        else if (inst_jr)  br_kind = BR_JR;
        else               br_kind = BR_NONE;
    end

    // fetch fault outranks a bad encoding
    assign ds_excode = ds_adel ? `EX_ADEL :
                       ~known  ? `EX_RI   :
                                 `EX_NO;
    assign ds_ex = ds_valid && (ds_excode != `EX_NO);

endmodule

`default_nettype wire

/* src/regfile.sv */
`default_nettype none

`include "cpu_defs.svh"

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr [`NUM_SRC],
    output word_t    rdata [`NUM_SRC],
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [`NUM_REGS];

    // r0 never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, no write-through
    always_comb begin
        for (int i = 0; i < `NUM_SRC; i++) begin
            if (raddr[i] == 5'd0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

`default_nettype wire

/* src/operand_bypass.sv */
`default_nettype none

module operand_bypass import cpu_pkg::*; (
    input  reg_idx_t src_idx,
    input  logic     src_used,
    input  word_t    rf_rdata,
    input  reg_idx_t exe_dest,
    input  reg_idx_t mem_dest,
    input  reg_idx_t wb_dest,
    input  word_t    exe_result,
    input  word_t    mem_result,
    input  word_t    wb_result,
    input  logic     es_load_op,
    input  logic     ws_flush,
    output word_t    value,
    output logic     fwd_hit,
    output logic     load_hit
);

    logic live;     // operand read and not r0
    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    assign live    = src_used && (src_idx != 5'd0);
    assign exe_hit = live && (src_idx == exe_dest);
    assign mem_hit = live && (src_idx == mem_dest);
    assign wb_hit  = live && (src_idx == wb_dest);

    assign fwd_hit = exe_hit | mem_hit | wb_hit;

    // youngest producer wins
    assign value = exe_hit ? exe_result :
                   mem_hit ? mem_result :
                   wb_hit  ? wb_result  :
                             rf_rdata;

    // load data not ready until mem
    assign load_hit = exe_hit & es_load_op & ~ws_flush;

endmodule

`default_nettype wire

/* src/branch_resolve.sv */
`default_nettype none

`include "cpu_defs.svh"

module branch_resolve import cpu_pkg::*; (
    input  logic        ds_valid,
    input  logic        ds_ready_go,
    input  logic        es_allowin,
    input  br_kind_t    br_kind,
    input  word_t       ds_pc,
    input  logic [15:0] imm,
    input  logic [25:0] jidx,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  logic        fwd_hit [`NUM_SRC],
    input  logic        load_hit [`NUM_SRC],
    output logic        br_taken,
    output word_t       br_target,
    output logic        br_stall,
    output logic        br_leaving
);

    word_t bd_pc;       // delay slot address
    word_t br_offset;
    word_t jump_target;
    logic  rs_eq_rt;
    logic  is_branch;
    logic  any_hit;     // an operand is still in flight downstream

    assign bd_pc       = ds_pc + 32'd4;
    assign br_offset   = {{14{imm[15]}}, imm, 2'b00};
    assign jump_target = {bd_pc[31:28], jidx, 2'b00};
    assign rs_eq_rt    = (rs_value == rt_value);
    assign is_branch   = (br_kind != BR_NONE);

    always_comb begin
        any_hit = 1'b0;
        for (int i = 0; i < `NUM_SRC; i++) begin
            any_hit = any_hit | fwd_hit[i] | load_hit[i];
        end
    end

    always_comb begin
        case (br_kind)
            BR_BEQ:  br_taken = rs_eq_rt;
            BR_BNE:  br_taken = ~rs_eq_rt;
            BR_J,
            BR_JAL,
            BR_JR:   br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
        br_taken = br_taken & ds_valid;
    end

    always_comb begin
        case (br_kind)
            BR_BEQ,
            BR_BNE:  br_target = bd_pc + br_offset;
            BR_JR:   br_target = rs_value;
            BR_J,
            BR_JAL:  br_target = jump_target;
            default: br_target = bd_pc;
        endcase
    end

    // fetch waits while the condition may still change
    assign br_stall   = ds_valid & is_branch & any_hit;
    assign br_leaving = br_taken & ds_ready_go & es_allowin;

endmodule

`default_nettype wire

/* src/id_stage.sv */
`default_nettype none

`include "cpu_defs.svh"

module id_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // from fetch
    input  logic        fs_to_ds_valid,
    input  word_t       fs_pc,
    input  word_t       fs_inst,
    input  logic        fs_adel,
    output logic        ds_allowin,
    // to execute
    input  logic        es_allowin,
    output logic        ds_to_es_valid,
    output word_t       es_pc,
    output alu_op_t     es_alu_op,
    output logic        es_src1_is_sa,
    output logic        es_src1_is_pc,
    output logic        es_src2_is_imm,
    output logic        es_src2_is_8,
    output logic        es_zero_ext,
    output logic        es_load_op_out,
    output logic        es_store_op,
    output logic        es_gr_we,
    output reg_idx_t    es_dest,
    output logic [15:0] es_imm,
    output word_t       es_rs_value,
    output word_t       es_rt_value,
    output logic        es_ex,
    output excode_t     es_excode,
    // forwarding from later stages
    input  reg_idx_t    exe_dest,
    input  reg_idx_t    mem_dest,
    input  reg_idx_t    wb_dest,
    input  word_t       exe_result,
    input  word_t       mem_result,
    input  word_t       wb_result,
    input  logic        es_load_op,
    input  logic        ws_flush,
    // write-back port
    input  logic        rf_we,
    input  reg_idx_t    rf_waddr,
    input  word_t       rf_wdata,
    // to fetch
    output logic        br_taken,
    output word_t       br_target,
    output logic        br_stall,
    output logic        br_leaving
);

    logic        ds_valid;
    word_t       ds_inst;
    logic        ds_adel;
    logic        ds_ready_go;
    logic [25:0] jidx;
    br_kind_t    br_kind;
    reg_idx_t    src_idx [`NUM_SRC];
    logic        src_used [`NUM_SRC];
    word_t       rf_rdata [`NUM_SRC];
    word_t       src_value [`NUM_SRC];
    logic        fwd_hit [`NUM_SRC];
    logic        load_hit [`NUM_SRC];

    decode_latch latch_inst (
        .clk(clk), .reset(reset), .fs_to_ds_valid(fs_to_ds_valid),
        .fs_pc(fs_pc), .fs_inst(fs_inst), .fs_adel(fs_adel),
        .es_allowin(es_allowin), .ws_flush(ws_flush), .load_hit(load_hit),
        .ds_allowin(ds_allowin), .ds_valid(ds_valid), .ds_pc(es_pc),
        .ds_inst(ds_inst), .ds_adel(ds_adel), .ds_ready_go(ds_ready_go),
        .ds_to_es_valid(ds_to_es_valid)
    );

    instr_decoder decoder_inst (
        .ds_inst(ds_inst), .ds_valid(ds_valid), .ds_adel(ds_adel),
        .src_idx(src_idx), .src_used(src_used), .alu_op(es_alu_op),
        .src1_is_sa(es_src1_is_sa), .src1_is_pc(es_src1_is_pc),
        .src2_is_imm(es_src2_is_imm), .src2_is_8(es_src2_is_8),
        .zero_ext(es_zero_ext), .load_op(es_load_op_out), .store_op(es_store_op),
        .gr_we(es_gr_we), .dest(es_dest), .imm(es_imm), .jidx(jidx),
        .br_kind(br_kind), .ds_ex(es_ex), .ds_excode(es_excode)
    );

    regfile regfile_inst (
        .clk(clk), .raddr(src_idx), .rdata(rf_rdata),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    // one bypass unit per source, rs then rt
    genvar i;
    generate
        for (i = 0; i < `NUM_SRC; i++) begin : g_src
            operand_bypass bypass_inst (
                .src_idx(src_idx[i]), .src_used(src_used[i]), .rf_rdata(rf_rdata[i]),
                .exe_dest(exe_dest), .mem_dest(mem_dest), .wb_dest(wb_dest),
                .exe_result(exe_result), .mem_result(mem_result), .wb_result(wb_result),
                .es_load_op(es_load_op), .ws_flush(ws_flush),
                .value(src_value[i]), .fwd_hit(fwd_hit[i]), .load_hit(load_hit[i])
            );
        end
    endgenerate

    assign es_rs_value = src_value[0];
    assign es_rt_value = src_value[1];

    branch_resolve branch_inst (
        .ds_valid(ds_valid), .ds_ready_go(ds_ready_go), .es_allowin(es_allowin),
        .br_kind(br_kind), .ds_pc(es_pc), .imm(es_imm), .jidx(jidx),
        .rs_value(src_value[0]), .rt_value(src_value[1]),
        .fwd_hit(fwd_hit), .load_hit(load_hit),
        .br_taken(br_taken), .br_target(br_target),
        .br_stall(br_stall), .br_leaving(br_leaving)
    );

endmodule

`default_nettype wire

/* verification/tb_id_stage.sv */
`default_nettype none

`include "cpu_defs.svh"

module tb_id_stage import cpu_pkg::*; ();

    typedef struct packed {
        word_t      inst;
        word_t      pc;
        logic       adel;
        reg_idx_t   pre_a;
        reg_idx_t   pre_b;
        reg_idx_t   exe_d;
        reg_idx_t   mem_d;
        reg_idx_t   wb_d;
        logic [2:0] ctl;        // es_load_op, es_allowin, ws_flush
        logic [1:0] rs_src;     // 0 regfile, 1 exe, 2 mem, 3 skip
        logic [1:0] rt_src;
        logic [3:0] hs;         // to_es_valid, allowin, br_stall, br_leaving
        logic [1:0] taken;      // 2 means skip
        logic [1:0] tgt;        // 0 skip, 1 offset, 2 index, 3 rs
        logic       chk_dec;
        reg_idx_t   dest;
        logic       we;
        logic [6:0] flags;      // sa, pc, imm, is_8, zero_ext, load, store
        alu_op_t    alu;
        excode_t    code;
        logic [1:0] mode;       // 1 release load, 2 hold
    } test_t;

    localparam word_t EXE_RES = 32'h1111_0001;
    localparam word_t MEM_RES = 32'h2222_0002;
    localparam word_t WB_RES  = 32'h3333_0003;

    logic clk = 1'b0;
    logic reset, fs_to_ds_valid, fs_adel, ds_allowin, es_allowin, ds_to_es_valid;
    word_t fs_pc, fs_inst, es_pc, es_rs_value, es_rt_value, br_target;
    word_t exe_result, mem_result, wb_result, rf_wdata;
    alu_op_t es_alu_op;
    logic es_src1_is_sa, es_src1_is_pc, es_src2_is_imm, es_src2_is_8, es_zero_ext;
    logic es_load_op_out, es_store_op, es_gr_we, es_ex, es_load_op, ws_flush, rf_we;
    logic br_taken, br_stall, br_leaving;
    logic [15:0] es_imm;
    reg_idx_t es_dest, exe_dest, mem_dest, wb_dest, rf_waddr;
    excode_t es_excode;

    test_t tests[$];
    word_t shadow [32];     // expected register contents
    int    errors = 0;
    int    failed_tests = 0;
    logic  test_bad;
    logic  timed_out = 1'b0;

    id_stage id_stage_inst (.*);

    always #2 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    function automatic word_t src_val(input logic [1:0] sel, input reg_idx_t idx);
        case (sel)
            2'd1:    return EXE_RES;
            2'd2:    return MEM_RES;
            default: return shadow[idx];
        endcase
    endfunction

    function automatic word_t exp_target(input test_t t);
        word_t seq;
        seq = t.pc + 32'd4;
        case (t.tgt)
            2'd1:    return seq + {{14{t.inst[15]}}, t.inst[15:0], 2'b00};
            2'd2:    return {seq[31:28], t.inst[25:0], 2'b00};
            default: return shadow[t.inst[25:21]];
        endcase
    endfunction

    // polls at 1 unit after each falling edge
    task automatic wait_high(input logic to_es, input string name);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 20 && !seen; n++) begin
            #1;
            seen = to_es ? ds_to_es_valid : ds_allowin;
            if (!seen) @(negedge clk);
        end
        if (!seen) begin
            $display("timeout: %s never went high", name);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_outputs(input test_t t);
        check(32'(ds_to_es_valid), 32'(t.hs[3]), "ds_to_es_valid");
        check(32'(ds_allowin), 32'(t.hs[2]), "ds_allowin");
        check(32'(br_stall), 32'(t.hs[1]), "br_stall");
        check(32'(br_leaving), 32'(t.hs[0]), "br_leaving");
        check(es_pc, t.pc, "es_pc");
        if (t.rs_src != 2'd3) check(es_rs_value, src_val(t.rs_src, t.inst[25:21]), "es_rs_value");
        if (t.rt_src != 2'd3) check(es_rt_value, src_val(t.rt_src, t.inst[20:16]), "es_rt_value");
        if (t.taken != 2'd2) check(32'(br_taken), 32'(t.taken), "br_taken");
        if (t.tgt != 2'd0) check(br_target, exp_target(t), "br_target");
        check(32'(es_ex), 32'(t.code != `EX_NO), "es_ex");
        check(32'(es_excode), 32'(t.code), "es_excode");
        if (t.chk_dec) begin
            check(32'(es_dest), 32'(t.dest), "es_dest");
            check(32'(es_gr_we), 32'(t.we), "es_gr_we");
            check(32'(es_alu_op), 32'(t.alu), "es_alu_op");
            check(32'(es_imm), 32'(t.inst[15:0]), "es_imm");
            check(32'({es_src1_is_sa, es_src1_is_pc, es_src2_is_imm, es_src2_is_8,
                       es_zero_ext, es_load_op_out, es_store_op}),
                  32'(t.flags), "decode flags");
        end
    endtask

    task automatic preload(input reg_idx_t idx);
        word_t v;
        v = $urandom;
        rf_we = 1'b1;
        rf_waddr = idx;
        rf_wdata = v;
        if (idx != 5'd0) shadow[idx] = v;   // r0 stays zero
        @(negedge clk);
    endtask

    task automatic run_test(input test_t t, input int n);
        test_bad = 1'b0;
        preload(t.pre_a);
        preload(t.pre_b);
        rf_we = 1'b0;
        wait_high(1'b0, "ds_allowin");
        if (timed_out) return;
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst = t.inst;
        fs_pc = t.pc;
        fs_adel = t.adel;
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        {exe_dest, mem_dest, wb_dest} = {t.exe_d, t.mem_d, t.wb_d};
        {es_load_op, es_allowin, ws_flush} = t.ctl;
        #1;
        check_outputs(t);
        if (t.mode == 2'd2) begin
            // a second fetch offered while execute is full
            @(negedge clk);
            fs_to_ds_valid = 1'b1;
            fs_pc = t.pc + 32'h100;
            fs_inst = 32'hFC000000;
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            #1;
            check_outputs(t);   // nothing moves under back-pressure
        end else if (t.mode == 2'd1) begin
            @(negedge clk);
            es_load_op = 1'b0;
            wait_high(1'b1, "ds_to_es_valid after load");
            check(32'(ds_allowin), 32'd1, "ds_allowin after load");
        end
        @(negedge clk);
        {exe_dest, mem_dest, wb_dest} = '0;
        {es_load_op, es_allowin, ws_flush} = 3'b010;
        if (test_bad || timed_out) failed_tests++;
        $display("test %0d %s", n, (test_bad || timed_out) ? "failed" : "ok");
    endtask

    task automatic add(input word_t inst, input word_t pc, input logic adel,
                       input reg_idx_t pa, input reg_idx_t pb, input logic [14:0] fwd,
                       input logic [2:0] ctl, input logic [1:0] rs, input logic [1:0] rt,
                       input logic [3:0] hs, input logic [1:0] tk, input logic [1:0] tg,
                       input logic chk, input reg_idx_t d, input logic we,
                       input logic [6:0] fl, input alu_op_t alu, input excode_t code,
                       input logic [1:0] mode);
        tests.push_back(test_t'{inst, pc, adel, pa, pb, fwd[14:10], fwd[9:5], fwd[4:0],
                                ctl, rs, rt, hs, tk, tg, chk, d, we, fl, alu, code, mode});
    endtask

    initial begin
        void'($urandom(34));
        foreach (shadow[i]) shadow[i] = '0;
        {reset, fs_to_ds_valid, fs_adel, es_load_op, ws_flush, rf_we} = 6'b100000;
        es_allowin = 1'b1;
        {fs_pc, fs_inst, exe_result, mem_result, wb_result, rf_wdata} = '0;
        {exe_dest, mem_dest, wb_dest, rf_waddr} = '0;
        exe_result = EXE_RES;
        mem_result = MEM_RES;
        wb_result = WB_RES;
        add(32'h00221821, 32'h400000, 0, 1, 2, 0, 3'b010, 0, 0, 4'b1100, 0, 0,
            1, 3, 1, 0, 12'h001, 5'h1f, 0);
        add(32'h00042821, 32'h400004, 0, 0, 4, 0, 3'b010, 0, 0, 4'b1100, 0, 0,
            1, 5, 1, 0, 12'h001, 5'h1f, 0);
        add(32'h00C74021, 32'h400008, 0, 6, 7, {5'd6, 5'd6, 5'd6}, 3'b010, 1, 0, 4'b1100,
            0, 0, 1, 8, 1, 0, 12'h001, 5'h1f, 0);
        add(32'h00C74021, 32'h40000c, 0, 6, 7, {5'd0, 5'd6, 5'd6}, 3'b010, 2, 0, 4'b1100,
            0, 0, 1, 8, 1, 0, 12'h001, 5'h1f, 0);
        add(32'h24C70010, 32'h400010, 0, 6, 7, {5'd7, 5'd7, 5'd7}, 3'b010, 0, 0, 4'b1100,
            0, 0, 1, 7, 1, 7'b0010000, 12'h001, 5'h1f, 0);
        add(32'h10220004, 32'h400100, 0, 1, 2, {5'd1, 10'd0}, 3'b110, 1, 0, 4'b0010,
            2, 1, 1, 0, 0, 0, 12'h000, 5'h1f, 1);
        add(32'h10A5FFFE, 32'h1000, 0, 5, 6, 0, 3'b010, 0, 0, 4'b1101, 1, 1,
            1, 0, 0, 0, 12'h000, 5'h1f, 0);
        add(32'h14A60008, 32'h2000, 0, 5, 6, 0, 3'b010, 0, 0, 4'b1101, 1, 1,
            1, 0, 0, 0, 12'h000, 5'h1f, 0);
        add(32'h08123456, 32'h90000000, 0, 1, 2, 0, 3'b010, 3, 3, 4'b1101, 1, 2,
            1, 0, 0, 0, 12'h000, 5'h1f, 0);
        add(32'h0C123456, 32'h40000010, 0, 1, 2, 0, 3'b010, 3, 3, 4'b1101, 1, 2,
            1, 31, 1, 7'b0101000, 12'h001, 5'h1f, 0);
        add(32'h01200008, 32'h3000, 0, 9, 1, 0, 3'b010, 0, 0, 4'b1101, 1, 3,
            1, 0, 0, 0, 12'h000, 5'h1f, 0);
        add(32'h356A8000, 32'h3004, 0, 11, 10, 0, 3'b010, 0, 3, 4'b1100, 0, 0,
            1, 10, 1, 7'b0010100, 12'h040, 5'h1f, 0);
        add(32'hADAC0004, 32'h3008, 0, 12, 13, 0, 3'b010, 0, 0, 4'b1100, 0, 0,
            1, 0, 0, 7'b0010001, 12'h001, 5'h1f, 0);
        add(32'h8DAE0000, 32'h300c, 0, 13, 14, 0, 3'b010, 0, 3, 4'b1100, 0, 0,
            1, 14, 1, 7'b0010010, 12'h001, 5'h1f, 0);
        add(32'h001078C0, 32'h3010, 0, 16, 15, 0, 3'b010, 0, 0, 4'b1100, 0, 0,
            1, 15, 1, 7'b1000000, 12'h100, 5'h1f, 0);
        add(32'hFC000000, 32'h3014, 0, 1, 2, 0, 3'b010, 3, 3, 4'b1100, 0, 0,
            0, 0, 0, 0, 12'h000, 5'h0a, 0);
        add(32'hFC000000, 32'h3019, 1, 1, 2, 0, 3'b010, 3, 3, 4'b1100, 0, 0,
            0, 0, 0, 0, 12'h000, 5'h04, 0);
        add(32'h00221821, 32'h3020, 0, 1, 2, 0, 3'b000, 0, 0, 4'b1000, 0, 0,
            1, 3, 1, 0, 12'h001, 5'h1f, 2);
        add(32'h00221821, 32'h3024, 0, 1, 2, 0, 3'b011, 0, 0, 4'b0100, 0, 0,
            1, 3, 1, 0, 12'h001, 5'h1f, 0);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        foreach (tests[i]) begin
            if (!timed_out) run_test(tests[i], i);
        end
        $display("%0d tests, %0d failed, %0d check errors", tests.size(), failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/cpu_pkg.sv
src/decode_latch.sv
src/instr_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_resolve.sv
src/id_stage.sv
verification/tb_id_stage.sv

/* Makefile */
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
